// File: Makefile
TOP := tb_br_rs

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f br_rs.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f br_rs.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: br_rs.f
+incdir+.
br_rs_pkg.sv
br_rs_entry.sv
br_rs_alloc.sv
br_rs_dispatch.sv
br_rs_retire.sv
br_rs_top.sv
tb_br_rs.sv

// File: br_rs_alloc.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module br_rs_alloc (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    flush_i,
    input  wire logic                    arbiter_valid_i,
    output logic                         arbiter_ready_o,
    input  wire logic [`BR_RS_DEPTH-1:0] entry_valid_i, // Per slot valid flags
    output logic [`BR_RS_DEPTH-1:0]      push_o         // One-hot load strobe
);

    logic [`BR_RS_IDX_LEN-1:0] tail_q; // Next slot to fill
    logic                      push;

    // ----------------------------------------
    // Push handshake
    // ----------------------------------------
    // Slots free in order, so only the tail needs checking
    assign arbiter_ready_o = !entry_valid_i[tail_q];
    assign push            = arbiter_valid_i && arbiter_ready_o;

    always_comb begin
        push_o         = '0;
        push_o[tail_q] = push;
    end

    // Tail pointer, wraps by overflow
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q <= '0;
        end else if (flush_i) begin
            tail_q <= '0;
        end else if (push) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    // Only the slot picked by push_o turns valid, and no other slot fills
    a_push_fill : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !flush_i |=> ((entry_valid_i & ~$past(entry_valid_i)) == $past(push_o))
    ) else $error("br_rs_alloc: slot filled without a matching push, valid %h", entry_valid_i);

endmodule

`default_nettype wire

// File: br_rs_defines.svh
`ifndef BR_RS_DEFINES_SVH
`define BR_RS_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define BR_RS_XLEN        32 // Data word, also the CDB value width
`define BR_RS_ROB_IDX_LEN 4  // ROB tag carried on the CDB
`define BR_RS_B_IMM       13 // B-type immediate, bit 0 included

// ----------------------------------------
// Station geometry
// ----------------------------------------
// Power of two only, pointers wrap by overflow
`define BR_RS_DEPTH       4
`define BR_RS_IDX_LEN     ($clog2(`BR_RS_DEPTH))

`endif

// File: br_rs_dispatch.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module br_rs_dispatch (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_n_i,
    input  wire logic                                     flush_i,
    input  wire br_rs_pkg::rs_entry_t [`BR_RS_DEPTH-1:0]  entries_i,
    input  wire logic [`BR_RS_DEPTH-1:0]                  ex_ready_i,
    input  wire logic                                     bu_ready_i,
    output logic                                          bu_valid_o,
    output br_rs_pkg::bu_req_t                            bu_req_o,
    input  wire logic                                     bu_valid_i, // Result strobe
    output logic [`BR_RS_DEPTH-1:0]                       dispatch_o, // One-hot busy set
    output logic [`BR_RS_DEPTH-1:0]                       result_o    // One-hot result write
);

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    logic [`BR_RS_IDX_LEN-1:0] ex_ptr_q;  // Oldest slot not yet dispatched
    logic [`BR_RS_IDX_LEN-1:0] res_ptr_q; // Oldest slot waiting for its result
    logic                      dispatch;
    logic                      result;
    br_rs_pkg::rs_issue_t      ex_issue;  // Payload at the dispatch pointer

    assign ex_issue = entries_i[ex_ptr_q].issue;

    // Strictly in order, a younger ready slot waits behind an older one
    assign bu_valid_o = ex_ready_i[ex_ptr_q];
    assign dispatch   = bu_valid_o && bu_ready_i;

    // Results come back in dispatch order
    assign result = bu_valid_i && entries_i[res_ptr_q].busy;

    // ----------------------------------------
    // Request to the branch unit
    // ----------------------------------------
    always_comb begin
        bu_req_o             = '0;
        bu_req_o.branch_type = ex_issue.branch_type;
        bu_req_o.rs1_value   = ex_issue.rs1_value;
        bu_req_o.rs2_value   = ex_issue.rs2_value;
        bu_req_o.imm         = ex_issue.imm;
        bu_req_o.pred_pc     = ex_issue.pred_pc;
        bu_req_o.pred_target = ex_issue.pred_target;
        bu_req_o.pred_taken  = ex_issue.pred_taken;
    end

    // Slot strobes
    always_comb begin
        dispatch_o            = '0;
        dispatch_o[ex_ptr_q]  = dispatch;
        result_o              = '0;
        result_o[res_ptr_q]   = result;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_ptr_q  <= '0;
            res_ptr_q <= '0;
        end else if (flush_i) begin
            ex_ptr_q  <= '0;
            res_ptr_q <= '0;
        end else begin
            if (dispatch) begin
                ex_ptr_q <= ex_ptr_q + 1'b1;
            end
            if (result) begin
                res_ptr_q <= res_ptr_q + 1'b1;
            end
        end
    end

    // Branch unit returns only what it was given
    a_result_busy : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        bu_valid_i |-> entries_i[res_ptr_q].busy
    ) else $error("br_rs_dispatch: result with no busy slot at %h", res_ptr_q);

endmodule

`default_nettype wire

// File: br_rs_entry.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module br_rs_entry (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  flush_i,
    input  wire logic                  push_i,      // Load from the arbiter
    input  wire br_rs_pkg::rs_issue_t  issue_i,
    input  wire logic                  dispatch_i,  // Accepted by the branch unit
    input  wire logic                  result_i,    // Branch unit result for this slot
    input  wire logic                  mispredict_i,
    input  wire logic                  pop_i,       // Retired onto the CDB
    input  wire logic                  cdb_valid_i,
    input  wire br_rs_pkg::cdb_data_t  cdb_data_i,
    output br_rs_pkg::rs_entry_t       entry_o,
    output logic                       ex_ready_o,
    output logic                       res_ready_o
);

    // ----------------------------------------
    // State
    // ----------------------------------------
    logic                 valid_q;
    logic                 busy_q;
    logic                 res_ready_q;
    logic                 mispredicted_q;
    br_rs_pkg::rs_issue_t issue_q;  // Payload plus operand ready bits

    logic rs1_hit; // CDB carries the missing first operand
    logic rs2_hit;

    // Snoop only while the slot is live, ready operands are never overwritten
    assign rs1_hit = cdb_valid_i && valid_q && !issue_q.rs1_ready
                     && (issue_q.rs1_idx == cdb_data_i.rob_idx);
    assign rs2_hit = cdb_valid_i && valid_q && !issue_q.rs2_ready
                     && (issue_q.rs2_idx == cdb_data_i.rob_idx);

    // Status flags
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q     <= 1'b0;
            busy_q      <= 1'b0;
            res_ready_q <= 1'b0;
        end else if (flush_i) begin
            valid_q     <= 1'b0;
            busy_q      <= 1'b0;
            res_ready_q <= 1'b0;
        end else begin
            if (push_i) begin
                valid_q     <= 1'b1;
                busy_q      <= 1'b0;
                res_ready_q <= 1'b0;
            end
            if (dispatch_i) begin
                busy_q <= 1'b1; // Keeps the slot out of dispatch
            end
            if (result_i) begin
                busy_q      <= 1'b0;
                res_ready_q <= 1'b1;
            end
            if (pop_i) begin
                valid_q     <= 1'b0; // Slot free for the tail again
                res_ready_q <= 1'b0;
            end
        end
    end

    // Payload and operand capture
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            issue_q <= issue_i;
        end else begin
            if (rs1_hit) begin
                issue_q.rs1_ready <= 1'b1;
                issue_q.rs1_value <= cdb_data_i.value.operand;
            end
            if (rs2_hit) begin
                issue_q.rs2_ready <= 1'b1;
                issue_q.rs2_value <= cdb_data_i.value.operand;
            end
        end
        if (result_i) begin
            mispredicted_q <= mispredict_i;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_comb begin
        entry_o              = '0;
        entry_o.valid        = valid_q;
        entry_o.busy         = busy_q;
        entry_o.res_ready    = res_ready_q;
        entry_o.mispredicted = mispredicted_q;
        entry_o.issue        = issue_q;
    end

    // A slot with its result back must not be sent again when the pointer wraps
    assign ex_ready_o  = valid_q && !busy_q && !res_ready_q
                         && issue_q.rs1_ready && issue_q.rs2_ready;
    assign res_ready_o = valid_q && res_ready_q;

    // Result can only follow a dispatch with both operands present
    a_res_after_ops : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        res_ready_o |-> (issue_q.rs1_ready && issue_q.rs2_ready)
    ) else $error("br_rs_entry: result ready without both operands");

endmodule

`default_nettype wire

// File: br_rs_pkg.sv
`default_nettype none

`include "br_rs_defines.svh"

package br_rs_pkg;

    // Branch condition evaluated by the branch unit
    typedef enum logic [2:0] {
        BEQ  = 3'd0,
        BNE  = 3'd1,
        BLT  = 3'd2,
        BGE  = 3'd3,
        BLTU = 3'd4,
        BGEU = 3'd5
    } branch_type_t;

    // Branch result layout inside a CDB word
    typedef struct packed {
        logic [`BR_RS_XLEN-2:0] pad;          // Always zero
        logic                   mispredicted; // LSB of the word
    } br_res_t;

    // Same word, read as operand when snooping, written as result on retire
    typedef union packed {
        logic [`BR_RS_XLEN-1:0] operand;
        br_res_t                br_res;
    } cdb_value_u;

    typedef struct packed {
        logic [`BR_RS_ROB_IDX_LEN-1:0] rob_idx; // Producer tag
        cdb_value_u                    value;
    } cdb_data_t;

    // Decode bundle as pushed by the issue arbiter
    typedef struct packed {
        branch_type_t                  branch_type;
        logic                          rs1_ready;
        logic [`BR_RS_ROB_IDX_LEN-1:0] rs1_idx;     // Tag to wait for
        logic [`BR_RS_XLEN-1:0]        rs1_value;
        logic                          rs2_ready;
        logic [`BR_RS_ROB_IDX_LEN-1:0] rs2_idx;
        logic [`BR_RS_XLEN-1:0]        rs2_value;
        logic [`BR_RS_B_IMM-1:0]       imm;
        logic [`BR_RS_XLEN-1:0]        pred_pc;     // PC of the branch
        logic [`BR_RS_XLEN-1:0]        pred_target; // Target from the predictor
        logic                          pred_taken;
        logic [`BR_RS_ROB_IDX_LEN-1:0] dest_idx;    // ROB slot of the branch itself
    } rs_issue_t;

    // Request to the branch unit
    typedef struct packed {
        branch_type_t                  branch_type;
        logic [`BR_RS_XLEN-1:0]        rs1_value;
        logic [`BR_RS_XLEN-1:0]        rs2_value;
        logic [`BR_RS_B_IMM-1:0]       imm;
        logic [`BR_RS_XLEN-1:0]        pred_pc;
        logic [`BR_RS_XLEN-1:0]        pred_target;
        logic                          pred_taken;
    } bu_req_t;

    // One station slot as seen by the pointer logic
    typedef struct packed {
        logic      valid;        // Slot holds a branch
        logic      busy;         // Sent to the branch unit, result pending
        logic      res_ready;    // Mispredict flag is back
        logic      mispredicted;
        rs_issue_t issue;
    } rs_entry_t;

endpackage

`default_nettype wire

// File: br_rs_retire.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module br_rs_retire (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_n_i,
    input  wire logic                                     flush_i,
    input  wire br_rs_pkg::rs_entry_t [`BR_RS_DEPTH-1:0]  entries_i,
    input  wire logic [`BR_RS_DEPTH-1:0]                  res_ready_i,
    input  wire logic                                     cdb_ready_i,
    output logic                                          cdb_valid_o,
    output br_rs_pkg::cdb_data_t                          cdb_data_o,
    output logic [`BR_RS_DEPTH-1:0]                       pop_o       // One-hot clear
);

    logic [`BR_RS_IDX_LEN-1:0] head_q;     // Oldest slot in the station
    br_rs_pkg::rs_entry_t      head_entry;
    logic                      pop;

    assign head_entry  = entries_i[head_q];
    assign cdb_valid_o = res_ready_i[head_q]; // Retire only from the head
    assign pop         = cdb_valid_o && cdb_ready_i;

    // ----------------------------------------
    // CDB word
    // ----------------------------------------
    always_comb begin
        cdb_data_o                          = '0;
        cdb_data_o.rob_idx                  = head_entry.issue.dest_idx;
        cdb_data_o.value.br_res.pad         = '0;
        cdb_data_o.value.br_res.mispredicted = head_entry.mispredicted;
    end

    always_comb begin
        pop_o         = '0;
        pop_o[head_q] = pop;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
        end else if (pop) begin
            head_q <= head_q + 1'b1; // Wraps with the tail
        end
    end

    // Stalled CDB output holds until taken
    a_cdb_hold : assert property (
        @(posedge clk_i) disable iff (!rst_n_i || flush_i)
        (cdb_valid_o && !cdb_ready_i) |=> (cdb_valid_o && $stable(cdb_data_o))
    ) else $error("br_rs_retire: cdb_data_o changed under stall, now %h", cdb_data_o);

endmodule

`default_nettype wire

// File: br_rs_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module br_rs_top (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  flush_i,
    // Issue arbiter
    input  wire logic                  arbiter_valid_i,
    output logic                       arbiter_ready_o,
    input  wire br_rs_pkg::rs_issue_t  issue_i,
    // Branch unit
    input  wire logic                  bu_ready_i,
    output logic                       bu_valid_o,
    output br_rs_pkg::bu_req_t         bu_req_o,
    input  wire logic                  bu_valid_i,
    input  wire logic                  mispredict_i,
    // Common data bus
    input  wire logic                  cdb_valid_i,
    input  wire br_rs_pkg::cdb_data_t  cdb_data_i,
    input  wire logic                  cdb_ready_i,
    output logic                       cdb_valid_o,
    output br_rs_pkg::cdb_data_t       cdb_data_o
);

    // ----------------------------------------
    // Slot strobes and status
    // ----------------------------------------
    logic [`BR_RS_DEPTH-1:0]                 push;
    logic [`BR_RS_DEPTH-1:0]                 dispatch;
    logic [`BR_RS_DEPTH-1:0]                 result;
    logic [`BR_RS_DEPTH-1:0]                 pop;
    logic [`BR_RS_DEPTH-1:0]                 entry_valid;
    logic [`BR_RS_DEPTH-1:0]                 ex_ready;
    logic [`BR_RS_DEPTH-1:0]                 res_ready;
    br_rs_pkg::rs_entry_t [`BR_RS_DEPTH-1:0] entries;

    br_rs_alloc u_alloc (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush_i),
        .arbiter_valid_i (arbiter_valid_i),
        .arbiter_ready_o (arbiter_ready_o),
        .entry_valid_i   (entry_valid),
        .push_o          (push)
    );

    // Slot array, CDB and mispredict flag fan out to all
    for (genvar i = 0; i < `BR_RS_DEPTH; i++) begin : g_entry
        br_rs_entry u_entry (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .flush_i      (flush_i),
            .push_i       (push[i]),
            .issue_i      (issue_i),
            .dispatch_i   (dispatch[i]),
            .result_i     (result[i]),
            .mispredict_i (mispredict_i),
            .pop_i        (pop[i]),
            .cdb_valid_i  (cdb_valid_i),
            .cdb_data_i   (cdb_data_i),
            .entry_o      (entries[i]),
            .ex_ready_o   (ex_ready[i]),
            .res_ready_o  (res_ready[i])
        );

        assign entry_valid[i] = entries[i].valid;
    end

    br_rs_dispatch u_dispatch (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .entries_i  (entries),
        .ex_ready_i (ex_ready),
        .bu_ready_i (bu_ready_i),
        .bu_valid_o (bu_valid_o),
        .bu_req_o   (bu_req_o),
        .bu_valid_i (bu_valid_i),
        .dispatch_o (dispatch),
        .result_o   (result)
    );

    br_rs_retire u_retire (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .entries_i   (entries),
        .res_ready_i (res_ready),
        .cdb_ready_i (cdb_ready_i),
        .cdb_valid_o (cdb_valid_o),
        .cdb_data_o  (cdb_data_o),
        .pop_o       (pop)
    );

endmodule

`default_nettype wire

// File: tb_br_rs.sv
`default_nettype none
`timescale 1ns/10ps

`include "br_rs_defines.svh"

module tb_br_rs;

    localparam int NUM_PUSH = 38;                  // Pushes over all phases
    localparam int LIMIT    = 40 * NUM_PUSH + 200; // Cycle budget of the run
    localparam int NUM_TAGS = 1 << `BR_RS_ROB_IDX_LEN;

    typedef struct packed {
        br_rs_pkg::bu_req_t            req;  // Request as the branch unit must see it
        logic [`BR_RS_ROB_IDX_LEN-1:0] dest;
        logic                          w1;   // rs1 waits on the CDB
        logic [`BR_RS_ROB_IDX_LEN-1:0] t1;
        logic [15:0]                   g1;   // Tag generation at push
        logic                          w2;
        logic [`BR_RS_ROB_IDX_LEN-1:0] t2;
        logic [15:0]                   g2;
    } sb_item_t;

    typedef struct packed {
        logic [`BR_RS_ROB_IDX_LEN-1:0] dest;
        logic                          flag; // Mispredict flag from the model
    } ret_item_t;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 flush_i;
    logic                 arbiter_valid_i;
    logic                 arbiter_ready_o;
    br_rs_pkg::rs_issue_t issue_i;
    logic                 bu_ready_i;
    logic                 bu_valid_o;
    br_rs_pkg::bu_req_t   bu_req_o;
    logic                 bu_valid_i;
    logic                 mispredict_i;
    logic                 cdb_valid_i;
    br_rs_pkg::cdb_data_t cdb_data_i;
    logic                 cdb_ready_i;
    logic                 cdb_valid_o;
    br_rs_pkg::cdb_data_t cdb_data_o;

    // ----------------------------------------
    // Scoreboard and model state
    // ----------------------------------------
    sb_item_t               exp_q[$];  // Pushed, not yet dispatched
    logic                   pend_q[$]; // Flags the branch unit model still owes
    ret_item_t              ret_q[$];  // Dispatched, not yet retired
    logic [`BR_RS_XLEN-1:0] tag_value [NUM_TAGS];
    logic                   tag_pending [NUM_TAGS]; // Value still to broadcast
    logic [15:0]            tag_gen [NUM_TAGS];     // Broadcasts done per tag

    logic                 exp_have;
    br_rs_pkg::bu_req_t   exp_req;
    logic                 exp_ops_done;
    logic                 ret_have;
    br_rs_pkg::cdb_data_t ret_word;
    int                   occ;      // Branches held by the station
    br_rs_pkg::bu_req_t   last_req; // Outputs one cycle back
    br_rs_pkg::cdb_data_t last_cdb;

    integer seed;
    logic   stim_on;
    logic   flush_req;
    logic   bu_hold;   // Branch unit refuses requests
    logic   cdb_hold;  // CDB refuses results
    logic   have_item; // issue_i holds a branch not yet taken
    int     ops_pct;   // Chance of an operand being ready at push
    int     push_budget;
    int     cycles;
    int     err_req;
    int     err_cdb;
    int     err_flow;

    br_rs_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic rand_pct(input int pct);
        return ((($random(seed)) & 32'h7fff_ffff) % 100) < pct;
    endfunction

    // Value a waiting operand will get, shared by all waiters on the tag
    function automatic logic [`BR_RS_XLEN-1:0] wait_value(
        input logic [`BR_RS_ROB_IDX_LEN-1:0] tag);
        if (!tag_pending[tag]) begin
            tag_value[tag]   = $random(seed);
            tag_pending[tag] = 1'b1;
        end
        return tag_value[tag];
    endfunction

    function automatic logic branch_mispredicted(input br_rs_pkg::bu_req_t req);
        logic taken;
        case (req.branch_type)
            br_rs_pkg::BEQ:  taken = req.rs1_value == req.rs2_value;
            br_rs_pkg::BNE:  taken = req.rs1_value != req.rs2_value;
            br_rs_pkg::BLT:  taken = $signed(req.rs1_value) < $signed(req.rs2_value);
            br_rs_pkg::BGE:  taken = $signed(req.rs1_value) >= $signed(req.rs2_value);
            br_rs_pkg::BLTU: taken = req.rs1_value < req.rs2_value;
            default:         taken = req.rs1_value >= req.rs2_value; // BGEU
        endcase
        return taken != req.pred_taken;
    endfunction

    task automatic make_item();
        issue_i.branch_type = br_rs_pkg::branch_type_t'(3'((($random(seed)) & 32'h7fff_ffff) % 6));
        issue_i.rs1_ready   = rand_pct(ops_pct);
        issue_i.rs1_idx     = 4'($random(seed));
        issue_i.rs1_value   = $random(seed); // Junk while not ready
        issue_i.rs2_ready   = rand_pct(ops_pct);
        issue_i.rs2_idx     = 4'($random(seed));
        issue_i.rs2_value   = rand_pct(30) ? issue_i.rs1_value : $random(seed);
        issue_i.imm         = 13'($random(seed));
        issue_i.pred_pc     = $random(seed);
        issue_i.pred_target = $random(seed);
        issue_i.pred_taken  = rand_pct(50);
        issue_i.dest_idx    = 4'($random(seed));
    endtask

    task automatic record_push();
        sb_item_t item;
        item.req.branch_type = issue_i.branch_type;
        item.req.rs1_value   = issue_i.rs1_value;
        item.req.rs2_value   = issue_i.rs2_value;
        if (!issue_i.rs1_ready) begin
            item.req.rs1_value = wait_value(issue_i.rs1_idx);
        end
        if (!issue_i.rs2_ready) begin
            item.req.rs2_value = wait_value(issue_i.rs2_idx);
        end
        item.req.imm         = issue_i.imm;
        item.req.pred_pc     = issue_i.pred_pc;
        item.req.pred_target = issue_i.pred_target;
        item.req.pred_taken  = issue_i.pred_taken;
        item.dest = issue_i.dest_idx;
        item.w1   = !issue_i.rs1_ready;
        item.t1   = issue_i.rs1_idx;
        item.g1   = tag_gen[issue_i.rs1_idx];
        item.w2   = !issue_i.rs2_ready;
        item.t2   = issue_i.rs2_idx;
        item.g2   = tag_gen[issue_i.rs2_idx];
        exp_q.push_back(item);
    endtask

    // Branch unit model takes the request and owes its flag in order
    task automatic take_dispatch();
        sb_item_t  item;
        ret_item_t ret;
        item     = exp_q.pop_front();
        ret.dest = item.dest;
        ret.flag = branch_mispredicted(item.req);
        pend_q.push_back(ret.flag);
        ret_q.push_back(ret);
    endtask

    function automatic void update_expect();
        exp_have     = exp_q.size() > 0;
        exp_req      = '0;
        exp_ops_done = 1'b0;
        ret_word     = '0;
        if (exp_have) begin
            exp_req      = exp_q[0].req;
            exp_ops_done = (!exp_q[0].w1 || tag_gen[exp_q[0].t1] != exp_q[0].g1)
                           && (!exp_q[0].w2 || tag_gen[exp_q[0].t2] != exp_q[0].g2);
        end
        ret_have = ret_q.size() > 0;
        if (ret_have) begin
            ret_word = {ret_q[0].dest, {(`BR_RS_XLEN-1){1'b0}}, ret_q[0].flag};
        end
        occ = exp_q.size() + ret_q.size();
    endfunction

    // Broadcast one pending tag now and then
    task automatic drive_broadcast();
        int                            start;
        logic [`BR_RS_ROB_IDX_LEN-1:0] t;
        cdb_valid_i = 1'b0;
        cdb_data_i  = '0;
        start       = $random(seed) & (NUM_TAGS - 1);
        if (rand_pct(50)) begin
            for (int k = 0; k < NUM_TAGS; k++) begin
                t = 4'(start + k);
                if (tag_pending[t] && !cdb_valid_i) begin
                    cdb_valid_i                = 1'b1;
                    cdb_data_i.rob_idx         = t;
                    cdb_data_i.value.operand   = tag_value[t];
                end
            end
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_drained();
        step();
        while (push_budget > 0 || have_item || occ > 0) begin
            step();
        end
    endtask

    task automatic report_counts();
        $display("Errors: request %0d, retire %0d, flow %0d", err_req, err_cdb, err_flow);
    endtask

    // ----------------------------------------
    // Monitor, updates the model at each edge
    // ----------------------------------------
    always @(posedge clk_i) begin
        last_req <= bu_req_o;
        last_cdb <= cdb_data_o;
        if (!rst_n_i || flush_i) begin
            exp_q.delete();
            pend_q.delete();
            ret_q.delete();
        end else begin
            if (cdb_valid_i) begin // Before the push, a same-cycle push misses it
                tag_pending[cdb_data_i.rob_idx] = 1'b0;
                tag_gen[cdb_data_i.rob_idx]++;
            end
            if (arbiter_valid_i && arbiter_ready_o) begin
                record_push();
                have_item = 1'b0;
            end
            if (bu_valid_o && bu_ready_i && exp_q.size() > 0) begin
                take_dispatch();
            end
            if (bu_valid_i && pend_q.size() > 0) begin
                void'(pend_q.pop_front());
            end
            if (cdb_valid_o && cdb_ready_i && ret_q.size() > 0) begin
                void'(ret_q.pop_front());
            end
        end
        update_expect();
    end

    // Stimulus on the falling edge
    always @(negedge clk_i) begin
        if (stim_on && flush_req) begin
            flush_i         = 1'b1; // Nothing else moves in the flush cycle
            arbiter_valid_i = 1'b0;
            bu_ready_i      = 1'b0;
            bu_valid_i      = 1'b0;
            cdb_valid_i     = 1'b0;
            cdb_ready_i     = 1'b0;
            have_item       = 1'b0;
            flush_req       = 1'b0;
        end else if (stim_on) begin
            flush_i = 1'b0;
            if (!have_item && push_budget > 0) begin
                make_item();
                have_item = 1'b1;
                push_budget--;
            end
            arbiter_valid_i = have_item;
            bu_ready_i      = !bu_hold && rand_pct(70);
            cdb_ready_i     = !cdb_hold && rand_pct(70);
            bu_valid_i      = (pend_q.size() > 0) && rand_pct(60);
            mispredict_i    = 1'b0;
            if (bu_valid_i) begin
                mispredict_i = pend_q[0];
            end
            drive_broadcast();
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_after_reset : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (!bu_valid_o && !cdb_valid_o && arbiter_ready_o))
    else begin
        err_flow++;
        $display("Station not empty after reset");
    end

    a_after_flush : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (!bu_valid_o && !cdb_valid_o && arbiter_ready_o))
    else begin
        err_flow++;
        $display("Station not empty after flush");
    end

    a_bu_req : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bu_valid_o && bu_ready_i) |-> (exp_have && bu_req_o == exp_req))
    else begin
        err_req++;
        $display("Fail bu_req_o: got %h, expected %h", $sampled(bu_req_o), $sampled(exp_req));
    end

    a_ops_seen : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bu_valid_o && bu_ready_i && exp_have) |-> exp_ops_done)
    else begin
        err_req++;
        $display("Branch dispatched before all its operand tags were broadcast");
    end

    a_cdb_out : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cdb_valid_o && cdb_ready_i) |-> (ret_have && cdb_data_o == ret_word))
    else begin
        err_cdb++;
        $display("Fail cdb_data_o: got %h, expected %h", $sampled(cdb_data_o), $sampled(ret_word));
    end

    a_occ : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        arbiter_ready_o == (occ < `BR_RS_DEPTH))
    else begin
        err_flow++;
        $display("Fail arbiter_ready_o: got %h, expected %h",
                 $sampled(arbiter_ready_o), $sampled(occ < `BR_RS_DEPTH));
    end

    a_bu_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bu_valid_o && !bu_ready_i && !flush_i) |=> (bu_valid_o && bu_req_o == last_req))
    else begin
        err_flow++;
        $display("Fail bu_req_o under stall: valid %h, held %h, now %h",
                 $sampled(bu_valid_o), $sampled(last_req), $sampled(bu_req_o));
    end

    a_cdb_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cdb_valid_o && !cdb_ready_i && !flush_i) |=> (cdb_valid_o && cdb_data_o == last_cdb))
    else begin
        err_flow++;
        $display("Fail cdb_data_o under stall: valid %h, held %h, now %h",
                 $sampled(cdb_valid_o), $sampled(last_cdb), $sampled(cdb_data_o));
    end

    // Run ends here if the station stops draining
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: station did not drain within %0d cycles", LIMIT);
        report_counts();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        seed            = 32'h6e3c;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        arbiter_valid_i = 1'b0;
        issue_i         = '0;
        bu_ready_i      = 1'b0;
        bu_valid_i      = 1'b0;
        mispredict_i    = 1'b0;
        cdb_valid_i     = 1'b0;
        cdb_data_i      = '0;
        cdb_ready_i     = 1'b0;
        stim_on         = 1'b0;
        flush_req       = 1'b0;
        bu_hold         = 1'b0;
        cdb_hold        = 1'b0;
        have_item       = 1'b0;
        ops_pct         = 50;
        push_budget     = 0;
        err_req         = 0;
        err_cdb         = 0;
        err_flow        = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_value[t]   = '0;
            tag_pending[t] = 1'b0;
            tag_gen[t]     = '0;
        end
        update_expect();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        step();
        stim_on = 1'b1;

        push_budget = 24; // Mixed traffic, half the operands from the CDB
        wait_drained();

        ops_pct     = 100; // Fill the station behind a stalled CDB
        cdb_hold    = 1'b1;
        push_budget = 6;
        while (ret_q.size() < `BR_RS_DEPTH) begin
            step();
        end
        repeat (10) step();
        cdb_hold = 1'b0;
        wait_drained();

        bu_hold     = 1'b1; // Stalled branch unit
        push_budget = 2;
        while (exp_q.size() < 2) begin
            step();
        end
        repeat (8) step();
        bu_hold = 1'b0;
        wait_drained();

        ops_pct     = 50; // Flush with branches in flight, then refill
        push_budget = 6;
        while (occ < 2) begin
            step();
        end
        flush_req = 1'b1;
        wait_drained();
        repeat (4) step();

        report_counts();
        if (err_req + err_cdb + err_flow == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
